// ==== alu_settings.svh ====
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

`define ALU_XLEN      32  // Register and operand width
`define ALU_RFIDX_W   5   // Register file index
`define ALU_PC_W      32  // Program counter width

// Shift amount comes from the low bits of op2
`define ALU_SHAMT_W   5

//////////////////////////////
// Link address
//////////////////////////////

// Return address for jal and jalr without compressed support
`define ALU_LINK_OFS  4

`endif

// ==== alu_pkg.sv ====
`include "alu_settings.svh"

package alu_pkg;

  //////////////////////////////
  // Decode enums
  //////////////////////////////

  typedef enum logic {
    GRP_ALU,
    GRP_BJP
  } exu_grp_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_LUI, ALU_ECALL, ALU_EBREAK, ALU_WFI
  } alu_op_e;

  typedef enum logic [2:0] {
    BJP_BEQ, BJP_BNE, BJP_BLT, BJP_BGE,
    BJP_BLTU, BJP_BGEU, BJP_JAL, BJP_JALR
  } bjp_op_e;

  //////////////////////////////
  // Stage payloads
  //////////////////////////////

  // Decoded instruction from the issue side
  typedef struct packed {
    exu_grp_e                grp;
    alu_op_e                 alu_op;
    bjp_op_e                 bjp_op;
    logic [`ALU_XLEN-1:0]    rs1;
    logic [`ALU_XLEN-1:0]    rs2;
    logic [`ALU_XLEN-1:0]    imm;
    logic                    use_imm;   // op2 from imm instead of rs2
    logic [`ALU_PC_W-1:0]    pc;
    logic [`ALU_RFIDX_W-1:0] rdidx;
    logic                    rdwen;
    logic                    bjp_prdt;  // Predicted taken
    logic                    ilegl;
    logic                    buserr;
    logic                    misalgn;
    logic                    rv32;
  } issue_t;

  // Fields that ride along to commit
  typedef struct packed {
    exu_grp_e                grp;
    logic [`ALU_PC_W-1:0]    pc;
    logic [`ALU_XLEN-1:0]    imm;
    logic [`ALU_XLEN-1:0]    link;
    logic [`ALU_RFIDX_W-1:0] rdidx;
    logic                    rdwen;
    logic                    prdt;
    logic                    ilegl;
    logic                    buserr;
    logic                    misalgn;
    logic                    ecall;
    logic                    ebreak;
    logic                    wfi;
    logic                    rv32;
  } ctrl_t;

  typedef struct packed {
    alu_op_e              op;
    logic                 cmp;      // Branch compare request
    bjp_op_e              bjp_op;
    logic [`ALU_XLEN-1:0] op1;
    logic [`ALU_XLEN-1:0] op2;
    ctrl_t                ctrl;
  } dp_req_t;

  typedef struct packed {
    ctrl_t                ctrl;
    logic [`ALU_XLEN-1:0] result;
    logic                 cmp_res;
  } res_t;

  typedef struct packed {
    logic [`ALU_PC_W-1:0] pc;
    logic [`ALU_XLEN-1:0] imm;
    logic                 rv32;
    logic                 bjp;
    logic                 bjp_prdt;
    logic                 bjp_rslv;
    logic                 ecall;
    logic                 ebreak;
    logic                 wfi;
    logic                 ifu_ilegl;
    logic                 ifu_buserr;
    logic                 ifu_misalgn;
  } cmt_t;

  typedef struct packed {
    logic [`ALU_XLEN-1:0]    wdat;
    logic [`ALU_RFIDX_W-1:0] rdidx;
  } wbck_t;

endpackage

// ==== alu_dispatch.sv ====
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_dispatch
  import alu_pkg::*;
(
  input  logic    clk,
  input  logic    i_rst_n,
  input  logic    i_valid,
  input  issue_t  i_issue,
  input  logic    i_ready,
  output logic    o_ready,
  output logic    o_valid,
  output dp_req_t o_req
);

  logic    excp;
  logic    is_jump;
  dp_req_t req_nxt;
  logic    vld_r;
  dp_req_t req_r;

  //////////////////////////////
  // Operand select
  //////////////////////////////

  assign excp    = i_issue.ilegl | i_issue.buserr | i_issue.misalgn;
  assign is_jump = (i_issue.bjp_op == BJP_JAL) | (i_issue.bjp_op == BJP_JALR);

  always_comb begin
    // Exception items fall through as add of zeros
    req_nxt.op     = ALU_ADD;
    req_nxt.cmp    = 1'b0;
    req_nxt.bjp_op = i_issue.bjp_op;
    req_nxt.op1    = '0;
    req_nxt.op2    = '0;

    if (!excp) begin
      if (i_issue.grp == GRP_ALU) begin
        req_nxt.op  = i_issue.alu_op;
        req_nxt.op1 = i_issue.rs1;
        req_nxt.op2 = i_issue.use_imm ? i_issue.imm : i_issue.rs2;
      end else begin
        // Branches compare rs1 against rs2 through the adder
        req_nxt.op  = is_jump ? ALU_ADD : ALU_SUB;
        req_nxt.cmp = ~is_jump;
        req_nxt.op1 = i_issue.rs1;
        req_nxt.op2 = i_issue.rs2;
      end
    end

    // Sidecar for commit
    req_nxt.ctrl.grp     = i_issue.grp;
    req_nxt.ctrl.pc      = i_issue.pc;
    req_nxt.ctrl.imm     = i_issue.imm;
    req_nxt.ctrl.link    = i_issue.pc + `ALU_PC_W'(`ALU_LINK_OFS);
    req_nxt.ctrl.rdidx   = i_issue.rdidx;
    req_nxt.ctrl.rdwen   = i_issue.rdwen;
    req_nxt.ctrl.prdt    = i_issue.bjp_prdt;
    req_nxt.ctrl.ilegl   = i_issue.ilegl;
    req_nxt.ctrl.buserr  = i_issue.buserr;
    req_nxt.ctrl.misalgn = i_issue.misalgn;
    req_nxt.ctrl.ecall   = (i_issue.alu_op == ALU_ECALL);
    req_nxt.ctrl.ebreak  = (i_issue.alu_op == ALU_EBREAK);
    req_nxt.ctrl.wfi     = (i_issue.alu_op == ALU_WFI);
    req_nxt.ctrl.rv32    = i_issue.rv32;
  end

  //////////////////////////////
  // Stage register
  //////////////////////////////

  // Free slot, or the datapath drains it this cycle
  assign o_ready = ~vld_r | i_ready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      vld_r <= 1'b0;
    end else if (o_ready) begin
      vld_r <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid & o_ready) begin
      req_r <= req_nxt;
    end
  end

  assign o_valid = vld_r;
  assign o_req   = req_r;

endmodule

// ==== alu_dpath.sv ====
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_dpath
  import alu_pkg::*;
(
  input  logic    clk,
  input  logic    i_rst_n,
  input  logic    i_valid,
  input  dp_req_t i_req,
  input  logic    i_ready,
  output logic    o_ready,
  output logic    o_valid,
  output res_t    o_res
);

  logic                    op_unsigned;
  logic                    op_sub;
  logic [`ALU_XLEN:0]      add_op1;
  logic [`ALU_XLEN:0]      add_op2;
  logic [`ALU_XLEN:0]      add_res;
  logic                    cmp_eq;
  logic                    cmp_lt;
  logic [`ALU_SHAMT_W-1:0] shamt;
  logic [`ALU_XLEN-1:0]    shf_rev;
  logic [`ALU_XLEN-1:0]    shf_in;
  logic [`ALU_XLEN-1:0]    shf_res;
  logic [`ALU_XLEN-1:0]    sll_res;
  logic [`ALU_XLEN-1:0]    sra_mask;
  logic [`ALU_XLEN-1:0]    sra_res;
  res_t                    res_nxt;
  logic                    vld_r;
  res_t                    res_r;

  //////////////////////////////
  // Shared adder
  //////////////////////////////

  assign op_unsigned = (i_req.op == ALU_SLTU)
                     | (i_req.cmp & ((i_req.bjp_op == BJP_BLTU) | (i_req.bjp_op == BJP_BGEU)));
  assign op_sub = i_req.cmp | (i_req.op == ALU_SUB)
                | (i_req.op == ALU_SLT) | (i_req.op == ALU_SLTU);

  // One extra bit so signed and unsigned compares both use the top bit
  assign add_op1 = {~op_unsigned & i_req.op1[`ALU_XLEN-1], i_req.op1};
  assign add_op2 = {~op_unsigned & i_req.op2[`ALU_XLEN-1], i_req.op2};
  assign add_res = add_op1 + (op_sub ? ~add_op2 : add_op2) + (`ALU_XLEN+1)'(op_sub);

  assign cmp_eq = (add_res[`ALU_XLEN-1:0] == '0);
  assign cmp_lt = add_res[`ALU_XLEN];  // Sign of the difference

  //////////////////////////////
  // Shifter
  //////////////////////////////

  assign shamt = i_req.op2[`ALU_SHAMT_W-1:0];

  // Left shift is a right shift on the reversed operand
  always_comb begin
    for (int i = 0; i < `ALU_XLEN; i++) begin
      shf_rev[i] = i_req.op1[`ALU_XLEN-1-i];
    end
    shf_in  = (i_req.op == ALU_SLL) ? shf_rev : i_req.op1;
    shf_res = shf_in >> shamt;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      sll_res[i] = shf_res[`ALU_XLEN-1-i];
    end
  end

  assign sra_mask = ~({`ALU_XLEN{1'b1}} >> shamt);  // Vacated upper bits
  assign sra_res  = shf_res | (sra_mask & {`ALU_XLEN{i_req.op1[`ALU_XLEN-1]}});

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    res_nxt.ctrl    = i_req.ctrl;
    res_nxt.cmp_res = 1'b0;
    if (i_req.ctrl.grp == GRP_BJP) begin
      res_nxt.result = i_req.ctrl.link;  // Link data for jal and jalr
      if (i_req.cmp) begin
        case (i_req.bjp_op)
          BJP_BEQ:  res_nxt.cmp_res = cmp_eq;
          BJP_BNE:  res_nxt.cmp_res = ~cmp_eq;
          BJP_BLT,
          BJP_BLTU: res_nxt.cmp_res = cmp_lt;
          BJP_BGE,
          BJP_BGEU: res_nxt.cmp_res = ~cmp_lt;
          default:  res_nxt.cmp_res = 1'b1;
        endcase
      end else begin
        res_nxt.cmp_res = 1'b1;  // Jumps always taken
      end
    end else begin
      case (i_req.op)
        ALU_ADD,
        ALU_SUB:  res_nxt.result = add_res[`ALU_XLEN-1:0];
        ALU_XOR:  res_nxt.result = i_req.op1 ^ i_req.op2;
        ALU_OR:   res_nxt.result = i_req.op1 | i_req.op2;
        ALU_AND:  res_nxt.result = i_req.op1 & i_req.op2;
        ALU_SLL:  res_nxt.result = sll_res;
        ALU_SRL:  res_nxt.result = shf_res;
        ALU_SRA:  res_nxt.result = sra_res;
        ALU_SLT,
        ALU_SLTU: res_nxt.result = `ALU_XLEN'(cmp_lt);
        ALU_LUI:  res_nxt.result = i_req.op2;
        default:  res_nxt.result = '0;  // ecall, ebreak, wfi
      endcase
    end
  end

  //////////////////////////////
  // Stage register
  //////////////////////////////

  assign o_ready = ~vld_r | i_ready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      vld_r <= 1'b0;
    end else if (o_ready) begin
      vld_r <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid & o_ready) begin
      res_r <= res_nxt;
    end
  end

  assign o_valid = vld_r;
  assign o_res   = res_r;

endmodule

// ==== alu_commit.sv ====
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_commit
  import alu_pkg::*;
(
  input  logic  clk,
  input  logic  i_rst_n,
  input  logic  i_valid,
  input  res_t  i_res,
  input  logic  i_cmt_ready,
  input  logic  i_wbck_ready,
  output logic  o_ready,
  output logic  o_cmt_valid,
  output cmt_t  o_cmt,
  output logic  o_wbck_valid,
  output wbck_t o_wbck
);

  logic vld_r;
  res_t res_r;
  logic err;
  logic is_bjp;
  logic is_alu;
  logic need_wbck;
  logic leave;

  //////////////////////////////
  // Item register
  //////////////////////////////

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      vld_r <= 1'b0;
    end else if (o_ready) begin
      vld_r <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid & o_ready) begin
      res_r <= i_res;
    end
  end

  //////////////////////////////
  // Interlocked handshake
  //////////////////////////////

  assign err       = res_r.ctrl.ilegl | res_r.ctrl.buserr | res_r.ctrl.misalgn;
  assign need_wbck = res_r.ctrl.rdwen & ~err;

  // Commit waits for write-back ready and vice versa
  assign o_cmt_valid  = vld_r & (~need_wbck | i_wbck_ready);
  assign o_wbck_valid = vld_r & need_wbck & i_cmt_ready;

  assign leave   = vld_r & i_cmt_ready & (~need_wbck | i_wbck_ready);
  assign o_ready = ~vld_r | leave;

  // Group flags only count for clean items
  assign is_bjp = ~err & (res_r.ctrl.grp == GRP_BJP);
  assign is_alu = ~err & (res_r.ctrl.grp == GRP_ALU);

  assign o_cmt.pc          = res_r.ctrl.pc;
  assign o_cmt.imm         = res_r.ctrl.imm;
  assign o_cmt.rv32        = res_r.ctrl.rv32;
  assign o_cmt.bjp         = is_bjp;
  assign o_cmt.bjp_prdt    = is_bjp & res_r.ctrl.prdt;
  assign o_cmt.bjp_rslv    = is_bjp & res_r.cmp_res;  // Resolved taken
  assign o_cmt.ecall       = is_alu & res_r.ctrl.ecall;
  assign o_cmt.ebreak      = is_alu & res_r.ctrl.ebreak;
  assign o_cmt.wfi         = is_alu & res_r.ctrl.wfi;
  assign o_cmt.ifu_ilegl   = res_r.ctrl.ilegl;
  assign o_cmt.ifu_buserr  = res_r.ctrl.buserr;
  assign o_cmt.ifu_misalgn = res_r.ctrl.misalgn;

  assign o_wbck.wdat  = err ? '0 : res_r.result;
  assign o_wbck.rdidx = res_r.ctrl.rdidx;

endmodule

// ==== alu_exu.sv ====
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_exu
  import alu_pkg::*;
(
  input  logic   clk,
  input  logic   i_rst_n,
  // Issue side
  input  logic   i_valid,
  output logic   o_ready,
  input  issue_t i_issue,
  // Commit side
  output logic   o_cmt_valid,
  input  logic   i_cmt_ready,
  output cmt_t   o_cmt,
  // Write-back side
  output logic   o_wbck_valid,
  input  logic   i_wbck_ready,
  output wbck_t  o_wbck
);

  //////////////////////////////
  // Stage links
  //////////////////////////////

  logic    s1_valid;
  logic    s1_ready;
  dp_req_t s1_req;
  logic    s2_valid;
  logic    s2_ready;
  res_t    s2_res;

  alu_dispatch u_dispatch (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_issue (i_issue),
    .i_ready (s1_ready),
    .o_ready (o_ready),
    .o_valid (s1_valid),
    .o_req   (s1_req)
  );

  alu_dpath u_dpath (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (s1_valid),
    .i_req   (s1_req),
    .i_ready (s2_ready),
    .o_ready (s1_ready),
    .o_valid (s2_valid),
    .o_res   (s2_res)
  );

  alu_commit u_commit (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (s2_valid),
    .i_res        (s2_res),
    .i_cmt_ready  (i_cmt_ready),
    .i_wbck_ready (i_wbck_ready),
    .o_ready      (s2_ready),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt        (o_cmt),
    .o_wbck_valid (o_wbck_valid),
    .o_wbck       (o_wbck)
  );

endmodule

// ==== tb_alu_exu.sv ====
`timescale 1ns/1ps
`include "alu_settings.svh"

module tb_alu_exu
  import alu_pkg::*;
();

  localparam int WAIT_LIMIT = 400;  // Cycles per wait loop
  localparam int N_STREAM   = 40;

  logic   clk;
  logic   i_rst_n;
  logic   i_valid;
  logic   o_ready;
  issue_t i_issue;
  logic   o_cmt_valid;
  logic   i_cmt_ready;
  cmt_t   o_cmt;
  logic   o_wbck_valid;
  logic   i_wbck_ready;
  wbck_t  o_wbck;

  logic [31:0] lfsr_state;
  int          err_cnt;
  int          chk_cnt;
  logic        bp_on;      // Random ready toggling active
  cmt_t        exp_cmt_q[$];
  wbck_t       exp_wbck_q[$];
  string       cmt_name_q[$];
  string       wbck_name_q[$];

  alu_exu dut0 (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_issue      (i_issue),
    .o_cmt_valid  (o_cmt_valid),
    .i_cmt_ready  (i_cmt_ready),
    .o_cmt        (o_cmt),
    .o_wbck_valid (o_wbck_valid),
    .i_wbck_ready (i_wbck_ready),
    .o_wbck       (o_wbck)
  );

  always #5 clk = ~clk;

  //////////////////////////////
  // Random source and checker
  //////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] ref_alu(input issue_t it);
    logic [31:0] b;
    b = it.use_imm ? it.imm : it.rs2;
    case (it.alu_op)
      ALU_ADD:  return it.rs1 + b;
      ALU_SUB:  return it.rs1 - b;
      ALU_XOR:  return it.rs1 ^ b;
      ALU_OR:   return it.rs1 | b;
      ALU_AND:  return it.rs1 & b;
      ALU_SLL:  return it.rs1 << b[4:0];
      ALU_SRL:  return it.rs1 >> b[4:0];
      ALU_SRA:  return $signed(it.rs1) >>> b[4:0];
      ALU_SLT:  return 32'($signed(it.rs1) < $signed(b));
      ALU_SLTU: return 32'(it.rs1 < b);
      ALU_LUI:  return b;
      default:  return 32'h0;  // System ops carry no data
    endcase
  endfunction

  function automatic logic ref_taken(input issue_t it);
    case (it.bjp_op)
      BJP_BEQ:  return it.rs1 == it.rs2;
      BJP_BNE:  return it.rs1 != it.rs2;
      BJP_BLT:  return $signed(it.rs1) < $signed(it.rs2);
      BJP_BGE:  return $signed(it.rs1) >= $signed(it.rs2);
      BJP_BLTU: return it.rs1 < it.rs2;
      BJP_BGEU: return it.rs1 >= it.rs2;
      default:  return 1'b1;  // jal and jalr
    endcase
  endfunction

  // Queue the commit and write-back an accepted item must produce
  task automatic expect_item(input issue_t it, input string name);
    cmt_t  c;
    wbck_t w;
    logic  err;
    logic  bjp;
    logic  alu;
    err = it.ilegl | it.buserr | it.misalgn;
    bjp = !err && (it.grp == GRP_BJP);
    alu = !err && (it.grp == GRP_ALU);
    c.pc          = it.pc;
    c.imm         = it.imm;
    c.rv32        = it.rv32;
    c.bjp         = bjp;
    c.bjp_prdt    = bjp & it.bjp_prdt;
    c.bjp_rslv    = bjp & ref_taken(it);
    c.ecall       = alu && (it.alu_op == ALU_ECALL);
    c.ebreak      = alu && (it.alu_op == ALU_EBREAK);
    c.wfi         = alu && (it.alu_op == ALU_WFI);
    c.ifu_ilegl   = it.ilegl;
    c.ifu_buserr  = it.buserr;
    c.ifu_misalgn = it.misalgn;
    exp_cmt_q.push_back(c);
    cmt_name_q.push_back(name);
    if (it.rdwen && !err) begin
      w.wdat  = bjp ? it.pc + 32'(`ALU_LINK_OFS) : ref_alu(it);  // Link for the branch group
      w.rdidx = it.rdidx;
      exp_wbck_q.push_back(w);
      wbck_name_q.push_back(name);
    end
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  // Sampled mid-cycle before the transfer edge
  always @(negedge clk) begin : monitor
    cmt_t  exp_c;
    wbck_t exp_w;
    string tname;
    if (i_rst_n) begin
      if (o_wbck_valid && !i_cmt_ready) begin
        err_cnt++;
        $display("Write-back valid was high while commit ready was low at %0t", $time);
      end
      if (o_cmt_valid && i_cmt_ready) begin
        if (exp_cmt_q.size() == 0) begin
          err_cnt++;
          $display("A commit arrived with no instruction pending at %0t", $time);
        end else begin
          exp_c = exp_cmt_q.pop_front();
          tname = cmt_name_q.pop_front();
          check({tname, " commit"}, 128'(exp_c), 128'(o_cmt));
          if (exp_c.ifu_ilegl || exp_c.ifu_buserr || exp_c.ifu_misalgn) begin
            check({tname, " faulted wdat"}, 128'(0), 128'(o_wbck.wdat));
          end
        end
      end
      if (o_wbck_valid && i_wbck_ready) begin
        if (exp_wbck_q.size() == 0) begin
          err_cnt++;
          $display("A write-back arrived that no instruction should make at %0t", $time);
        end else begin
          exp_w = exp_wbck_q.pop_front();
          tname = wbck_name_q.pop_front();
          check({tname, " write-back"}, 128'(exp_w), 128'(o_wbck));
        end
      end
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Called 1 ns after a rising edge and returns at the same phase
  task automatic send(input issue_t it, input string name);
    int   waited;
    logic stuck;
    waited = 0;
    stuck  = 1'b0;
    i_valid = 1'b1;
    i_issue = it;
    @(negedge clk);
    while (!o_ready && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (o_ready) begin
      expect_item(it, name);
    end else begin
      stuck = 1'b1;
      err_cnt++;
      $display("Timeout: the DUT never accepted %s", name);
    end
    @(posedge clk);
    #1;
    if (stuck) begin
      i_valid = 1'b0;
    end
  endtask

  task automatic idle_input();
    i_valid = 1'b0;
    i_issue = '0;
  endtask

  task automatic drain(input string name);
    int waited;
    waited = 0;
    while ((exp_cmt_q.size() != 0 || exp_wbck_q.size() != 0) && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_cmt_q.size() != 0 || exp_wbck_q.size() != 0) begin
      err_cnt++;
      $display("Timeout: %s left %0d commits and %0d write-backs outstanding",
               name, exp_cmt_q.size(), exp_wbck_q.size());
      exp_cmt_q.delete();
      exp_wbck_q.delete();
      cmt_name_q.delete();
      wbck_name_q.delete();
    end
    repeat (2) @(posedge clk);  // Catch stray outputs
    #1;
  endtask

  function automatic issue_t base_issue(input exu_grp_e grp);
    issue_t it;
    it       = '0;
    it.grp   = grp;
    it.rs1   = rand_bits(32);
    it.rs2   = rand_bits(32);
    it.imm   = rand_bits(32);
    it.pc    = rand_bits(32) & ~32'h3;  // Word aligned
    it.rdidx = 5'(rand_bits(5));
    it.rv32  = 1'b1;
    return it;
  endfunction

  function automatic issue_t rand_issue();
    issue_t     it;
    logic [2:0] x;
    int         sel;
    it          = base_issue(exu_grp_e'(1'(rand_bits(1))));
    it.alu_op   = alu_op_e'(4'(rand_bits(4) % 32'd14));
    it.bjp_op   = bjp_op_e'(3'(rand_bits(3)));
    it.use_imm  = 1'(rand_bits(1));
    it.rdwen    = 1'(rand_bits(1));
    it.bjp_prdt = 1'(rand_bits(1));
    x = 3'(rand_bits(3));
    if (x == 3'd0) begin  // About one in eight faults
      sel = int'(rand_bits(2) % 32'd3);
      it.ilegl   = (sel == 0);
      it.buserr  = (sel == 1);
      it.misalgn = (sel == 2);
    end
    return it;
  endfunction

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_reset();
    check("reset o_cmt_valid", 128'(1'b0), 128'(o_cmt_valid));
    check("reset o_wbck_valid", 128'(1'b0), 128'(o_wbck_valid));
    check("reset o_ready", 128'(1'b1), 128'(o_ready));
  endtask

  task automatic test_regular();
    issue_t it;
    for (int k = 0; k <= 10; k++) begin
      for (int m = 0; m < 2; m++) begin
        it = base_issue(GRP_ALU);
        it.alu_op  = alu_op_e'(k[3:0]);
        it.use_imm = m[0];
        it.rdwen   = 1'b1;
        send(it, $sformatf("regular op %0d imm %0d", k, m));
      end
    end
    idle_input();
    drain("regular ops");
  endtask

  task automatic test_no_wbck();
    issue_t it;
    it = base_issue(GRP_ALU);
    it.alu_op = ALU_ADD;
    send(it, "add without rdwen");
    for (int k = 11; k <= 13; k++) begin  // ecall, ebreak, wfi
      it = base_issue(GRP_ALU);
      it.alu_op = alu_op_e'(k[3:0]);
      send(it, $sformatf("system op %0d", k));
    end
    idle_input();
    drain("no write-back");
  endtask

  task automatic test_branch();
    issue_t      it;
    logic [31:0] lhs [5];
    logic [31:0] rhs [5];
    // Equal, less, greater, then pairs where signed and unsigned disagree
    lhs = '{32'h0000_1234, 32'h0000_0005, 32'h0000_0009, 32'hffff_fff0, 32'h0000_0010};
    rhs = '{32'h0000_1234, 32'h0000_0009, 32'h0000_0005, 32'h0000_0010, 32'hffff_fff0};
    for (int k = 0; k <= 5; k++) begin
      for (int p = 0; p < 5; p++) begin
        it = base_issue(GRP_BJP);
        it.bjp_op   = bjp_op_e'(k[2:0]);
        it.rs1      = lhs[p];
        it.rs2      = rhs[p];
        it.bjp_prdt = 1'(rand_bits(1));
        send(it, $sformatf("branch op %0d case %0d", k, p));
      end
    end
    for (int k = 6; k <= 7; k++) begin  // jal, jalr
      it = base_issue(GRP_BJP);
      it.bjp_op   = bjp_op_e'(k[2:0]);
      it.alu_op   = ALU_WFI;  // Stray ALU code on a jump
      it.rdwen    = 1'b1;
      it.bjp_prdt = 1'b1;
      send(it, $sformatf("jump op %0d", k));
    end
    idle_input();
    drain("branches");
  endtask

  task automatic test_excp();
    issue_t it;
    for (int e = 0; e < 3; e++) begin
      it = base_issue(exu_grp_e'(e[0]));
      it.alu_op   = ALU_ECALL;
      it.bjp_prdt = 1'b1;
      it.rdwen    = 1'b1;
      it.ilegl    = (e == 0);
      it.buserr   = (e == 1);
      it.misalgn  = (e == 2);
      send(it, $sformatf("fetch exception %0d", e));
    end
    idle_input();
    drain("fetch exceptions");
  endtask

  task automatic test_backpressure();
    issue_t stream [N_STREAM];
    for (int i = 0; i < N_STREAM; i++) begin
      stream[i] = rand_issue();
    end
    bp_on = 1'b1;
    fork
      begin
        for (int i = 0; i < N_STREAM; i++) begin
          send(stream[i], $sformatf("stream item %0d", i));
        end
        idle_input();
        drain("back-pressure stream");
        @(negedge clk);
        bp_on = 1'b0;
        @(posedge clk);
        #1;
      end
      begin
        while (bp_on) begin
          i_cmt_ready  = 1'(rand_bits(1));
          i_wbck_ready = 1'(rand_bits(1));
          @(posedge clk);
          #1;
        end
        i_cmt_ready  = 1'b1;
        i_wbck_ready = 1'b1;
      end
    join
  endtask

  initial begin
    clk          = 1'b0;
    i_rst_n      = 1'b0;
    i_valid      = 1'b0;
    i_issue      = '0;
    i_cmt_ready  = 1'b1;
    i_wbck_ready = 1'b1;
    lfsr_state   = 32'h10e44303;
    err_cnt      = 0;
    chk_cnt      = 0;
    bp_on        = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    i_rst_n = 1'b1;
    test_reset();
    test_regular();
    test_no_wbck();
    test_branch();
    test_excp();
    test_backpressure();
    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
alu_pkg.sv
alu_dispatch.sv
alu_dpath.sv
alu_commit.sv
alu_exu.sv
tb_alu_exu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_alu_exu
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS     := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard *.svh)
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := *** TEST PASSED ***

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
